/* Bender.yml */
package:
  name: adc_dac_calib

sources:
  - logic/calib_pkg.sv
  - logic/regmap_pkg.sv
  - logic/axil_regs.sv
  - logic/adc_frontend.sv
  - logic/linear_cal.sv
  - logic/dac_backend.sv
  - logic/adc_dac_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_adc_dac_top.sv

/* adc_dac_calib.f */
+incdir+verif
logic/calib_pkg.sv
logic/regmap_pkg.sv
logic/axil_regs.sv
logic/adc_frontend.sv
logic/linear_cal.sv
logic/dac_backend.sv
logic/adc_dac_top.sv
verif/tb_adc_dac_top.sv

/* logic/adc_dac_top.sv */
`timescale 1ns/1ps

module adc_dac_top #(
  parameter int unsigned CHN_N = 2
)(
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  // ADC pins
  input  logic [CHN_N-1:0][calib_pkg::PIN_W-1:0] adc_dat_i,
  // AXI4-Lite slave
  input  logic [regmap_pkg::ADDR_W-1:0]          s_awaddr_i,
  input  logic                                   s_awvalid_i,
  input  logic [regmap_pkg::DATA_W-1:0]          s_wdata_i,
  input  logic [regmap_pkg::DATA_W/8-1:0]        s_wstrb_i,
  input  logic                                   s_wvalid_i,
  input  logic                                   s_bready_i,
  output logic                                   s_awready_o,
  output logic                                   s_wready_o,
  output logic                                   s_bvalid_o,
  output regmap_pkg::resp_e                      s_bresp_o,
  input  logic [regmap_pkg::ADDR_W-1:0]          s_araddr_i,
  input  logic                                   s_arvalid_i,
  input  logic                                   s_rready_i,
  output logic                                   s_arready_o,
  output logic                                   s_rvalid_o,
  output logic [regmap_pkg::DATA_W-1:0]          s_rdata_o,
  output regmap_pkg::resp_e                      s_rresp_o,
  // acquisition stream, no back-pressure
  output calib_pkg::sample_t [CHN_N-1:0]         acq_dat_o,
  output logic                                   acq_vld_o,
  // DAC pins
  output logic [CHN_N-1:0][calib_pkg::PIN_W-1:0] dac_dat_o
);

////////////////////
// local signals
////////////////////

// configuration
calib_pkg::gain_t   [CHN_N-1:0] adc_gain;
calib_pkg::offset_t [CHN_N-1:0] adc_offs;
calib_pkg::gain_t   [CHN_N-1:0] dac_gain;
calib_pkg::offset_t [CHN_N-1:0] dac_offs;
logic               [CHN_N-1:0] loop;
calib_pkg::sample_t [CHN_N-1:0] dac_set;
// streams
calib_pkg::sample_t [CHN_N-1:0] raw_dat;
logic                           raw_vld;
calib_pkg::sample_t [CHN_N-1:0] dac_cal;
logic               [CHN_N-1:0] acq_vld;

////////////////////
// register file
////////////////////

axil_regs #(
  .CHN_N (CHN_N)
) axil_regs_inst (
  .adc_clk     (adc_clk),
  .top_rst     (top_rst),
  .s_awaddr_i  (s_awaddr_i),
  .s_awvalid_i (s_awvalid_i),
  .s_wdata_i   (s_wdata_i),
  .s_wstrb_i   (s_wstrb_i),
  .s_wvalid_i  (s_wvalid_i),
  .s_bready_i  (s_bready_i),
  .s_awready_o (s_awready_o),
  .s_wready_o  (s_wready_o),
  .s_bvalid_o  (s_bvalid_o),
  .s_bresp_o   (s_bresp_o),
  .s_araddr_i  (s_araddr_i),
  .s_arvalid_i (s_arvalid_i),
  .s_rready_i  (s_rready_i),
  .s_arready_o (s_arready_o),
  .s_rvalid_o  (s_rvalid_o),
  .s_rdata_o   (s_rdata_o),
  .s_rresp_o   (s_rresp_o),
  .adc_gain_o  (adc_gain),
  .adc_offs_o  (adc_offs),
  .dac_gain_o  (dac_gain),
  .dac_offs_o  (dac_offs),
  .loop_o      (loop),
  .dac_set_o   (dac_set)
);

////////////////////
// ADC path
////////////////////

adc_frontend #(
  .CHN_N (CHN_N)
) adc_frontend_inst (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .adc_dat_i (adc_dat_i),
  .loop_i    (loop),
  .dac_cal_i (dac_cal),
  .raw_dat_o (raw_dat),
  .raw_vld_o (raw_vld)
);

for (genvar i = 0; i < CHN_N; i++) begin : gen_adc_cal
  linear_cal linear_cal_inst (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (raw_dat[i]),
    .vld_i   (raw_vld),
    .gain_i  (adc_gain[i]),
    .offs_i  (adc_offs[i]),
    .dat_o   (acq_dat_o[i]),
    .vld_o   (acq_vld[i])
  );
end

// all channels share one valid
assign acq_vld_o = acq_vld[0];

////////////////////
// DAC path
////////////////////

dac_backend #(
  .CHN_N (CHN_N)
) dac_backend_inst (
  .adc_clk    (adc_clk),
  .top_rst    (top_rst),
  .dac_set_i  (dac_set),
  .dac_gain_i (dac_gain),
  .dac_offs_i (dac_offs),
  .dac_cal_o  (dac_cal),
  .dac_dat_o  (dac_dat_o)
);

endmodule

/* logic/adc_frontend.sv */
`timescale 1ns/1ps

module adc_frontend #(
  parameter int unsigned CHN_N = 2
)(
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  // converter pins, lowest two bits not present
  input  logic [CHN_N-1:0][calib_pkg::PIN_W-1:0] adc_dat_i,
  // loopback from the DAC side
  input  logic               [CHN_N-1:0]         loop_i,
  input  calib_pkg::sample_t [CHN_N-1:0]         dac_cal_i,
  // raw signed stream
  output calib_pkg::sample_t [CHN_N-1:0]         raw_dat_o,
  output logic                                   raw_vld_o
);

////////////////////
// pin capture
////////////////////

calib_pkg::sample_t [CHN_N-1:0] smp_q;

// one register stage at the pins, format converted on the way in
always_ff @(posedge adc_clk) begin
  for (int i = 0; i < CHN_N; i++) begin
    smp_q[i] <= calib_pkg::fmt_flip(adc_dat_i[i]);
  end
end

// converter never stalls, valid from the first cycle out of reset
always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    raw_vld_o <= 1'b0;
  end else begin
    raw_vld_o <= 1'b1;
  end
end

////////////////////
// loopback mux
////////////////////

// combinational, adds no latency
always_comb begin
  for (int i = 0; i < CHN_N; i++) begin
    raw_dat_o[i] = loop_i[i] ? dac_cal_i[i] : smp_q[i];
  end
end

endmodule

/* logic/axil_regs.sv */
`timescale 1ns/1ps

module axil_regs #(
  parameter int unsigned CHN_N = 2
)(
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  // write address, data and response
  input  logic [regmap_pkg::ADDR_W-1:0]           s_awaddr_i,
  input  logic                                    s_awvalid_i,
  input  logic [regmap_pkg::DATA_W-1:0]           s_wdata_i,
  input  logic [regmap_pkg::DATA_W/8-1:0]         s_wstrb_i,
  input  logic                                    s_wvalid_i,
  input  logic                                    s_bready_i,
  output logic                                    s_awready_o,
  output logic                                    s_wready_o,
  output logic                                    s_bvalid_o,
  output regmap_pkg::resp_e                       s_bresp_o,
  // read address and data
  input  logic [regmap_pkg::ADDR_W-1:0]           s_araddr_i,
  input  logic                                    s_arvalid_i,
  input  logic                                    s_rready_i,
  output logic                                    s_arready_o,
  output logic                                    s_rvalid_o,
  output logic [regmap_pkg::DATA_W-1:0]           s_rdata_o,
  output regmap_pkg::resp_e                       s_rresp_o,
  // configuration
  output calib_pkg::gain_t   [CHN_N-1:0]          adc_gain_o,
  output calib_pkg::offset_t [CHN_N-1:0]          adc_offs_o,
  output calib_pkg::gain_t   [CHN_N-1:0]          dac_gain_o,
  output calib_pkg::offset_t [CHN_N-1:0]          dac_offs_o,
  output logic               [CHN_N-1:0]          loop_o,
  output calib_pkg::sample_t [CHN_N-1:0]          dac_set_o
);

localparam int unsigned AW = regmap_pkg::ADDR_W;
localparam int unsigned DW = regmap_pkg::DATA_W;

////////////////////
// decode helpers
////////////////////

// low two address bits ignored
function automatic regmap_pkg::reg_addr_e word_of(input logic [AW-1:0] a);
  return regmap_pkg::reg_addr_e'({a[AW-1:2], 2'b00});
endfunction

// channel 1 registers exist only with two channels
function automatic logic addr_hit(input logic [AW-1:0] a);
  logic hit;
  hit = 1'b0;
  case (word_of(a))
    regmap_pkg::REG_CTRL,
    regmap_pkg::REG_ADC_GAIN0, regmap_pkg::REG_ADC_OFFS0,
    regmap_pkg::REG_DAC_GAIN0, regmap_pkg::REG_DAC_OFFS0,
    regmap_pkg::REG_DAC_SET0: hit = 1'b1;
    regmap_pkg::REG_ADC_GAIN1, regmap_pkg::REG_ADC_OFFS1,
    regmap_pkg::REG_DAC_GAIN1, regmap_pkg::REG_DAC_OFFS1,
    regmap_pkg::REG_DAC_SET1: hit = (CHN_N > 1);
    default: hit = 1'b0;
  endcase
  return hit;
endfunction

// readback view, fields sign extended, zero when unmapped
function automatic logic [DW-1:0] reg_rd(input logic [AW-1:0] a);
  logic [DW-1:0] v;
  int unsigned ch;
  v = '0;
  // odd word in each pair is channel 1
  ch = a[2];
  if (addr_hit(a)) begin
    case (word_of(a))
      regmap_pkg::REG_CTRL: v = DW'(loop_o);
      regmap_pkg::REG_ADC_GAIN0, regmap_pkg::REG_ADC_GAIN1: v = DW'($signed(adc_gain_o[ch]));
      regmap_pkg::REG_ADC_OFFS0, regmap_pkg::REG_ADC_OFFS1: v = DW'($signed(adc_offs_o[ch]));
      regmap_pkg::REG_DAC_GAIN0, regmap_pkg::REG_DAC_GAIN1: v = DW'($signed(dac_gain_o[ch]));
      regmap_pkg::REG_DAC_OFFS0, regmap_pkg::REG_DAC_OFFS1: v = DW'($signed(dac_offs_o[ch]));
      regmap_pkg::REG_DAC_SET0,  regmap_pkg::REG_DAC_SET1:  v = DW'($signed(dac_set_o[ch]));
      default: v = '0;
    endcase
  end
  return v;
endfunction

// byte lanes from wdata where the strobe is set
function automatic logic [DW-1:0] merge(
  input logic [DW-1:0]   old,
  input logic [DW-1:0]   dat,
  input logic [DW/8-1:0] strb
);
  logic [DW-1:0] v;
  v = old;
  for (int b = 0; b < DW/8; b++) begin
    if (strb[b]) begin
      v[8*b +: 8] = dat[8*b +: 8];
    end
  end
  return v;
endfunction

////////////////////
// write channel
////////////////////

regmap_pkg::bus_state_e wr_state;
logic                   wr_hs;
logic                   wr_hit;
logic [DW-1:0]          wr_val;

// address and data accepted together
assign wr_hs       = (wr_state == regmap_pkg::ST_IDLE) & s_awvalid_i & s_wvalid_i;
assign s_awready_o = wr_hs;
assign s_wready_o  = wr_hs;
assign s_bvalid_o  = (wr_state == regmap_pkg::ST_RESP);

always_comb begin
  wr_hit = addr_hit(s_awaddr_i);
  wr_val = merge(reg_rd(s_awaddr_i), s_wdata_i, s_wstrb_i);
end

always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    wr_state  <= regmap_pkg::ST_IDLE;
    s_bresp_o <= regmap_pkg::RESP_OKAY;
  end else begin
    case (wr_state)
      regmap_pkg::ST_IDLE: begin
        if (wr_hs) begin
          wr_state  <= regmap_pkg::ST_RESP;
          s_bresp_o <= wr_hit ? regmap_pkg::RESP_OKAY : regmap_pkg::RESP_SLVERR;
        end
      end
      // hold response until master takes it
      default: begin
        if (s_bready_i) begin
          wr_state <= regmap_pkg::ST_IDLE;
        end
      end
    endcase
  end
end

// register file
always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    adc_gain_o <= {CHN_N{calib_pkg::gain_t'(calib_pkg::GAIN_UNITY)}};
    dac_gain_o <= {CHN_N{calib_pkg::gain_t'(calib_pkg::GAIN_UNITY)}};
    adc_offs_o <= '0;
    dac_offs_o <= '0;
    dac_set_o  <= '0;
    loop_o     <= '0;
  end else if (wr_hs && wr_hit) begin
    case (word_of(s_awaddr_i))
      regmap_pkg::REG_CTRL: loop_o <= wr_val[CHN_N-1:0];
      regmap_pkg::REG_ADC_GAIN0, regmap_pkg::REG_ADC_GAIN1:
        adc_gain_o[s_awaddr_i[2]] <= wr_val[calib_pkg::GAIN_W-1:0];
      regmap_pkg::REG_ADC_OFFS0, regmap_pkg::REG_ADC_OFFS1:
        adc_offs_o[s_awaddr_i[2]] <= wr_val[calib_pkg::SAMPLE_W-1:0];
      regmap_pkg::REG_DAC_GAIN0, regmap_pkg::REG_DAC_GAIN1:
        dac_gain_o[s_awaddr_i[2]] <= wr_val[calib_pkg::GAIN_W-1:0];
      regmap_pkg::REG_DAC_OFFS0, regmap_pkg::REG_DAC_OFFS1:
        dac_offs_o[s_awaddr_i[2]] <= wr_val[calib_pkg::SAMPLE_W-1:0];
      regmap_pkg::REG_DAC_SET0, regmap_pkg::REG_DAC_SET1:
        dac_set_o[s_awaddr_i[2]] <= wr_val[calib_pkg::SAMPLE_W-1:0];
      default: ;
    endcase
  end
end

////////////////////
// read channel
////////////////////

regmap_pkg::bus_state_e rd_state;
logic                   rd_hs;

assign rd_hs       = (rd_state == regmap_pkg::ST_IDLE) & s_arvalid_i;
assign s_arready_o = rd_hs;
assign s_rvalid_o  = (rd_state == regmap_pkg::ST_RESP);

always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    rd_state  <= regmap_pkg::ST_IDLE;
    s_rresp_o <= regmap_pkg::RESP_OKAY;
  end else begin
    case (rd_state)
      regmap_pkg::ST_IDLE: begin
        if (rd_hs) begin
          rd_state  <= regmap_pkg::ST_RESP;
          s_rresp_o <= addr_hit(s_araddr_i) ? regmap_pkg::RESP_OKAY
                                            : regmap_pkg::RESP_SLVERR;
        end
      end
      default: begin
        if (s_rready_i) begin
          rd_state <= regmap_pkg::ST_IDLE;
        end
      end
    endcase
  end
end

// read data captured at the address handshake
always_ff @(posedge adc_clk) begin
  if (rd_hs) begin
    s_rdata_o <= reg_rd(s_araddr_i);
  end
end

endmodule

/* logic/calib_pkg.sv */
package calib_pkg;

  ////////////////////
  // sample stream
  ////////////////////

  // signed sample width after conversion
  localparam int unsigned SAMPLE_W = 14;
  // converter pin word, pins 15 down to 2
  localparam int unsigned PIN_W = 14;

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // clamp limits of the signed sample range
  localparam int SAMPLE_MAX = 2**(SAMPLE_W-1) - 1;
  localparam int SAMPLE_MIN = -(2**(SAMPLE_W-1));

  ////////////////////
  // coefficients
  ////////////////////

  // gain is signed fixed point with 14 fraction bits
  localparam int unsigned GAIN_W = 16;
  localparam int unsigned GAIN_FRAC = 14;
  localparam int GAIN_UNITY = 2**GAIN_FRAC;

  typedef logic signed [GAIN_W-1:0] gain_t;
  // offset has the same width as a sample
  typedef logic signed [SAMPLE_W-1:0] offset_t;

  // inverted offset binary <-> two's complement
  // same rule in both directions: keep top bit, invert the rest
  function automatic logic [PIN_W-1:0] fmt_flip(input logic [PIN_W-1:0] x);
    return {x[PIN_W-1], ~x[PIN_W-2:0]};
  endfunction

endpackage

/* logic/dac_backend.sv */
`timescale 1ns/1ps

module dac_backend #(
  parameter int unsigned CHN_N = 2
)(
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  // setpoints and coefficients from the register file
  input  calib_pkg::sample_t [CHN_N-1:0]         dac_set_i,
  input  calib_pkg::gain_t   [CHN_N-1:0]         dac_gain_i,
  input  calib_pkg::offset_t [CHN_N-1:0]         dac_offs_i,
  // calibrated samples, also used for loopback
  output calib_pkg::sample_t [CHN_N-1:0]         dac_cal_o,
  // converter pins
  output logic [CHN_N-1:0][calib_pkg::PIN_W-1:0] dac_dat_o
);

logic [CHN_N-1:0] cal_vld;

////////////////////
// calibration
////////////////////

// setpoint register is always valid, pipe fill tracked by vld
for (genvar i = 0; i < CHN_N; i++) begin : gen_dac_cal
  linear_cal linear_cal_inst (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (dac_set_i[i]),
    .vld_i   (1'b1),
    .gain_i  (dac_gain_i[i]),
    .offs_i  (dac_offs_i[i]),
    .dat_o   (dac_cal_o[i]),
    .vld_o   (cal_vld[i])
  );
end

////////////////////
// output register
////////////////////

// signed back to inverted offset binary
// holds the code for zero until the pipe is filled
always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    dac_dat_o <= {CHN_N{calib_pkg::fmt_flip('0)}};
  end else begin
    for (int i = 0; i < CHN_N; i++) begin
      if (cal_vld[i]) begin
        dac_dat_o[i] <= calib_pkg::fmt_flip(dac_cal_o[i]);
      end
    end
  end
end

endmodule

/* logic/linear_cal.sv */
`timescale 1ns/1ps

module linear_cal (
  input  logic                adc_clk,
  input  logic                top_rst,
  // input sample
  input  calib_pkg::sample_t  dat_i,
  input  logic                vld_i,
  // coefficients
  input  calib_pkg::gain_t    gain_i,
  input  calib_pkg::offset_t  offs_i,
  // calibrated sample, two cycles later
  output calib_pkg::sample_t  dat_o,
  output logic                vld_o
);

// full product, then product with fraction dropped, then sum with carry
localparam int unsigned PROD_W  = calib_pkg::SAMPLE_W + calib_pkg::GAIN_W;
localparam int unsigned SHIFT_W = PROD_W - calib_pkg::GAIN_FRAC;
localparam int unsigned SUM_W   = SHIFT_W + 1;

logic signed [PROD_W-1:0]  prod_q;
logic signed [SHIFT_W-1:0] shifted;
logic signed [SUM_W-1:0]   sum;
calib_pkg::sample_t        sat;
logic                      vld_q;

////////////////////
// stage 1 multiply
////////////////////

// both operands signed, extended to product width
always_ff @(posedge adc_clk) begin
  prod_q <= dat_i * gain_i;
end

////////////////////
// stage 2 add, clamp
////////////////////

always_comb begin
  // drop fraction bits, sign kept
  shifted = SHIFT_W'(prod_q >>> calib_pkg::GAIN_FRAC);
  sum     = SUM_W'(shifted) + SUM_W'(offs_i);
  // saturate to signed sample range
  if (sum > calib_pkg::SAMPLE_MAX) begin
    sat = calib_pkg::sample_t'(calib_pkg::SAMPLE_MAX);
  end else if (sum < calib_pkg::SAMPLE_MIN) begin
    sat = calib_pkg::sample_t'(calib_pkg::SAMPLE_MIN);
  end else begin
    sat = sum[calib_pkg::SAMPLE_W-1:0];
  end
end

always_ff @(posedge adc_clk) begin
  dat_o <= sat;
end

// valid follows data through both stages
always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    vld_q <= 1'b0;
    vld_o <= 1'b0;
  end else begin
    vld_q <= vld_i;
    vld_o <= vld_q;
  end
end

endmodule

/* logic/regmap_pkg.sv */
package regmap_pkg;

  ////////////////////
  // AXI4-Lite bus
  ////////////////////

  localparam int unsigned ADDR_W = 8;
  localparam int unsigned DATA_W = 32;

  // byte offsets of the mapped registers
  typedef enum logic [ADDR_W-1:0] {
    // bit n is the loopback enable of channel n
    REG_CTRL      = 8'h00,
    REG_ADC_GAIN0 = 8'h10,
    REG_ADC_GAIN1 = 8'h14,
    REG_ADC_OFFS0 = 8'h18,
    REG_ADC_OFFS1 = 8'h1C,
    REG_DAC_GAIN0 = 8'h20,
    REG_DAC_GAIN1 = 8'h24,
    REG_DAC_OFFS0 = 8'h28,
    REG_DAC_OFFS1 = 8'h2C,
    // DAC setpoints
    REG_DAC_SET0  = 8'h30,
    REG_DAC_SET1  = 8'h34
  } reg_addr_e;

  // bresp / rresp codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // write and read channel states
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RESP = 1'b1
  } bus_state_e;

endpackage

/* verif/axil_bfm.svh */
`ifndef AXIL_BFM_SVH
`define AXIL_BFM_SVH

// single write, address and data presented together
task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output regmap_pkg::resp_e resp);
  int waited;
  waited = 0;
  @(posedge adc_clk);
  #1;
  s_awaddr_i  = addr;
  s_awvalid_i = 1'b1;
  s_wdata_i   = data;
  s_wstrb_i   = strb;
  s_wvalid_i  = 1'b1;
  s_bready_i  = 1'b1;
  // ready is combinational, look at it mid cycle
  @(negedge adc_clk);
  while (!(s_awready_o && s_wready_o)) begin
    waited++;
    if (waited > BUS_WAIT) stop_run("write request was never accepted by the slave");
    @(negedge adc_clk);
  end
  @(posedge adc_clk);
  #1;
  s_awvalid_i = 1'b0;
  s_wvalid_i  = 1'b0;
  @(negedge adc_clk);
  while (!s_bvalid_o) begin
    waited++;
    if (waited > BUS_WAIT) stop_run("write response never arrived");
    @(negedge adc_clk);
  end
  resp = s_bresp_o;
  @(posedge adc_clk);
  #1;
  s_bready_i = 1'b0;
endtask

// single read
task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                         output regmap_pkg::resp_e resp);
  int waited;
  waited = 0;
  @(posedge adc_clk);
  #1;
  s_araddr_i  = addr;
  s_arvalid_i = 1'b1;
  s_rready_i  = 1'b1;
  @(negedge adc_clk);
  while (!s_arready_o) begin
    waited++;
    if (waited > BUS_WAIT) stop_run("read request was never accepted by the slave");
    @(negedge adc_clk);
  end
  @(posedge adc_clk);
  #1;
  s_arvalid_i = 1'b0;
  @(negedge adc_clk);
  while (!s_rvalid_o) begin
    waited++;
    if (waited > BUS_WAIT) stop_run("read response never arrived");
    @(negedge adc_clk);
  end
  data = s_rdata_o;
  resp = s_rresp_o;
  @(posedge adc_clk);
  #1;
  s_rready_i = 1'b0;
endtask

`endif

/* verif/tb_adc_dac_top.sv */
`timescale 1ns/1ps

module tb_adc_dac_top;

localparam int CLK_PERIOD = 8;
localparam int RST_CYC    = 8;
localparam int ITER       = 128;
localparam int SEED       = 32'hba3;
localparam int CHN        = 2;
localparam int BUS_WAIT   = 50;

logic                   adc_clk = 1'b0;
logic                   top_rst;
logic [CHN-1:0][13:0]   adc_dat_i;
logic [7:0]             s_awaddr_i;
logic                   s_awvalid_i;
logic [31:0]            s_wdata_i;
logic [3:0]             s_wstrb_i;
logic                   s_wvalid_i;
logic                   s_bready_i;
logic                   s_awready_o;
logic                   s_wready_o;
logic                   s_bvalid_o;
regmap_pkg::resp_e      s_bresp_o;
logic [7:0]             s_araddr_i;
logic                   s_arvalid_i;
logic                   s_rready_i;
logic                   s_arready_o;
logic                   s_rvalid_o;
logic [31:0]            s_rdata_o;
regmap_pkg::resp_e      s_rresp_o;
calib_pkg::sample_t [CHN-1:0] acq_dat_o;
logic                   acq_vld_o;
logic [CHN-1:0][13:0]   dac_dat_o;

// shadow copies of the register file
int         ag_sh[CHN];
int         ao_sh[CHN];
int         dg_sh[CHN];
int         do_sh[CHN];
int         set_sh[CHN];
logic [1:0] loop_sh;
// high while coefficients move through the pipes
logic       busy;

logic [7:0] map_addr[11] = '{regmap_pkg::REG_CTRL,
  regmap_pkg::REG_ADC_GAIN0, regmap_pkg::REG_ADC_GAIN1,
  regmap_pkg::REG_ADC_OFFS0, regmap_pkg::REG_ADC_OFFS1,
  regmap_pkg::REG_DAC_GAIN0, regmap_pkg::REG_DAC_GAIN1,
  regmap_pkg::REG_DAC_OFFS0, regmap_pkg::REG_DAC_OFFS1,
  regmap_pkg::REG_DAC_SET0, regmap_pkg::REG_DAC_SET1};

always #(CLK_PERIOD/2) adc_clk = ~adc_clk;

adc_dac_top #(.CHN_N(CHN)) adc_dac_top_inst (.*);

`include "axil_bfm.svh"

////////////////////
// reference model
////////////////////

// inverted offset pins to signed
function automatic int pin_to_smp(input logic [13:0] p);
  logic signed [13:0] s;
  s = {p[13], ~p[12:0]};
  return s;
endfunction

function automatic logic [13:0] smp_to_pin(input int v);
  logic [13:0] b;
  b = v[13:0];
  return {b[13], ~b[12:0]};
endfunction

// multiply, drop 14 fraction bits, add offset, clamp
function automatic int cal(input int x, input int g, input int o);
  longint p;
  p = (longint'(x) * longint'(g)) >>> 14;
  p = p + o;
  if (p > 8191) p = 8191;
  if (p < -8192) p = -8192;
  return int'(p);
endfunction

function automatic int exp_acq(input int c, input logic [13:0] pin);
  int x;
  // loopback takes the calibrated setpoint instead of the pins
  x = loop_sh[c] ? cal(set_sh[c], dg_sh[c], do_sh[c]) : pin_to_smp(pin);
  return cal(x, ag_sh[c], ao_sh[c]);
endfunction

function automatic int reset_value(input logic [7:0] a);
  case (a)
    regmap_pkg::REG_ADC_GAIN0, regmap_pkg::REG_ADC_GAIN1,
    regmap_pkg::REG_DAC_GAIN0, regmap_pkg::REG_DAC_GAIN1: return 16384;
    default: return 0;
  endcase
endfunction

// sign-extended readback of the shadows
function automatic int shadow_value(input logic [7:0] a);
  case (a)
    regmap_pkg::REG_CTRL: return int'(loop_sh);
    regmap_pkg::REG_ADC_GAIN0, regmap_pkg::REG_ADC_GAIN1: return ag_sh[a[2]];
    regmap_pkg::REG_ADC_OFFS0, regmap_pkg::REG_ADC_OFFS1: return ao_sh[a[2]];
    regmap_pkg::REG_DAC_GAIN0, regmap_pkg::REG_DAC_GAIN1: return dg_sh[a[2]];
    regmap_pkg::REG_DAC_OFFS0, regmap_pkg::REG_DAC_OFFS1: return do_sh[a[2]];
    default: return set_sh[a[2]];
  endcase
endfunction

////////////////////
// checking
////////////////////

task automatic stop_run(input string msg);
  $display("%s", msg);
  $display("test failed");
  $fatal(1);
endtask

task automatic value_error(input string what, input int expv, input int actv);
  stop_run($sformatf("** Error at %0t ns: %s expected %0d actual %0d",
                     $time, what, expv, actv));
endtask

task automatic check_eq(input string what, input int expv, input int actv);
  assert (expv == actv) else value_error(what, expv, actv);
endtask

// handshakes quiet while reset is applied, looked at mid cycle
assert property (@(negedge adc_clk) top_rst |-> !(acq_vld_o || s_awready_o ||
    s_wready_o || s_arready_o || s_bvalid_o || s_rvalid_o))
  else stop_run("ready or valid output active during reset");

// stream never drops valid
assert property (@(posedge adc_clk) disable iff (top_rst) $past(acq_vld_o) |-> acq_vld_o)
  else stop_run("acq_vld_o dropped after it was raised");

for (genvar c = 0; c < CHN; c++) begin : gen_chk
  // pins to stream, 3 cycles
  assert property (@(posedge adc_clk) disable iff (top_rst || busy)
      acq_vld_o |-> int'(acq_dat_o[c]) == exp_acq(c, $past(adc_dat_i[c], 3)))
    else value_error("acq_dat_o", exp_acq(c, $past(adc_dat_i[c], 3)), int'(acq_dat_o[c]));
  assert property (@(posedge adc_clk) disable iff (top_rst || busy)
      dac_dat_o[c] == smp_to_pin(cal(set_sh[c], dg_sh[c], do_sh[c])))
    else value_error("dac_dat_o", smp_to_pin(cal(set_sh[c], dg_sh[c], do_sh[c])),
                     dac_dat_o[c]);
end

////////////////////
// stimulus
////////////////////

// full-word write that also tracks the shadows
task automatic cfg_write(input logic [7:0] a, input logic [31:0] d);
  regmap_pkg::resp_e r;
  busy = 1'b1;
  axil_write(a, d, 4'hf, r);
  check_eq("bresp", regmap_pkg::RESP_OKAY, r);
  case (a)
    regmap_pkg::REG_CTRL: loop_sh = d[1:0];
    regmap_pkg::REG_ADC_GAIN0, regmap_pkg::REG_ADC_GAIN1: ag_sh[a[2]] = int'($signed(d[15:0]));
    regmap_pkg::REG_ADC_OFFS0, regmap_pkg::REG_ADC_OFFS1: ao_sh[a[2]] = int'($signed(d[13:0]));
    regmap_pkg::REG_DAC_GAIN0, regmap_pkg::REG_DAC_GAIN1: dg_sh[a[2]] = int'($signed(d[15:0]));
    regmap_pkg::REG_DAC_OFFS0, regmap_pkg::REG_DAC_OFFS1: do_sh[a[2]] = int'($signed(d[13:0]));
    default: set_sh[a[2]] = int'($signed(d[13:0]));
  endcase
endtask

// let the longest path (loopback, 4 cycles) drain
task automatic settle();
  repeat (5) @(posedge adc_clk);
  #1;
  busy = 1'b0;
endtask

task automatic run_pins(input int n);
  repeat (n) begin
    @(posedge adc_clk);
    #1;
    for (int c = 0; c < CHN; c++) adc_dat_i[c] = $urandom;
  end
endtask

task automatic check_map();
  logic [31:0]       d;
  regmap_pkg::resp_e r;
  foreach (map_addr[i]) begin
    axil_read(map_addr[i], d, r);
    check_eq("rresp", regmap_pkg::RESP_OKAY, r);
    check_eq("rdata", shadow_value(map_addr[i]), d);
  end
endtask

// watchdog
initial begin
  #((ITER * 20 + RST_CYC) * CLK_PERIOD);
  stop_run("watchdog expired before the tests completed");
end

initial begin
  logic [31:0]       d;
  regmap_pkg::resp_e r;
  void'($urandom(SEED));
  {s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i} = '0;
  {s_awaddr_i, s_wdata_i, s_wstrb_i, s_araddr_i, adc_dat_i} = '0;
  top_rst = 1'b1;
  busy    = 1'b1;
  loop_sh = '0;
  for (int c = 0; c < CHN; c++) begin
    ag_sh[c]  = reset_value(regmap_pkg::REG_ADC_GAIN0);
    dg_sh[c]  = reset_value(regmap_pkg::REG_DAC_GAIN0);
    ao_sh[c]  = 0;
    do_sh[c]  = 0;
    set_sh[c] = 0;
  end
  repeat (RST_CYC) @(posedge adc_clk);
  #1;
  top_rst = 1'b0;
  // valid rises on the third edge after release
  for (int k = 1; k <= 3; k++) begin
    @(posedge adc_clk);
    #1;
    check_eq("acq_vld_o", k == 3, acq_vld_o);
  end
  foreach (map_addr[i]) begin
    axil_read(map_addr[i], d, r);
    check_eq("reset rdata", reset_value(map_addr[i]), d);
  end
  // readback of random values
  foreach (map_addr[i]) cfg_write(map_addr[i], $urandom);
  check_map();
  // byte strobe keeps upper bytes
  cfg_write(regmap_pkg::REG_ADC_GAIN0, 32'h0000_7f55);
  axil_write(regmap_pkg::REG_ADC_GAIN0, 32'h0000_aa12, 4'b0001, r);
  check_eq("strobe bresp", regmap_pkg::RESP_OKAY, r);
  ag_sh[0] = 32'h7f12;
  check_map();
  // unmapped offsets
  axil_write(8'h40, 32'hffff_ffff, 4'hf, r);
  check_eq("unmapped bresp", regmap_pkg::RESP_SLVERR, r);
  axil_read(8'h48, d, r);
  check_eq("unmapped rresp", regmap_pkg::RESP_SLVERR, r);
  check_eq("unmapped rdata", 0, d);
  check_map();
  foreach (map_addr[i]) cfg_write(map_addr[i], reset_value(map_addr[i]));
  settle();
  // default coefficients
  run_pins(ITER);
  // random ADC coefficients, both clamp limits forced
  for (int k = 0; k < ITER / 8; k++) begin
    for (int c = 0; c < CHN; c++) begin
      d = (k % 4 == 0) ? 32'h7fff : (k % 4 == 1) ? 32'hffff_8000 : $urandom;
      cfg_write(regmap_pkg::REG_ADC_GAIN0 + 4 * c, d);
      d = (k % 4 == 0) ? 32'h1fff : (k % 4 == 1) ? 32'hffff_e000 : $urandom;
      cfg_write(regmap_pkg::REG_ADC_OFFS0 + 4 * c, d);
    end
    settle();
    run_pins(8);
  end
  // random DAC setpoints and coefficients
  for (int k = 0; k < ITER / 8; k++) begin
    for (int c = 0; c < CHN; c++) begin
      cfg_write(regmap_pkg::REG_DAC_GAIN0 + 4 * c, $urandom);
      cfg_write(regmap_pkg::REG_DAC_OFFS0 + 4 * c, $urandom);
      cfg_write(regmap_pkg::REG_DAC_SET0 + 4 * c, $urandom);
    end
    settle();
    run_pins(4);
  end
  // loopback on one channel at a time
  for (int c = 0; c < CHN; c++) begin
    cfg_write(regmap_pkg::REG_CTRL, 1 << c);
    repeat (4) begin
      cfg_write(regmap_pkg::REG_DAC_SET0 + 4 * c, $urandom);
      settle();
      run_pins(4);
    end
  end
  $display("test passed");
  $finish;
end

endmodule
